//--- src/mem_pkg.sv
package mem_pkg;

    localparam int WORD_W     = 32;              // data word
    localparam int REG_ADDR_W = 5;               // gpr address

    // memory op is {class, size}
    localparam int         MEM_OP_W        = 4;
    localparam logic [1:0] MEM_CLASS_NONE  = 2'b00;
    localparam logic [1:0] MEM_CLASS_LOAD  = 2'b01;
    localparam logic [1:0] MEM_CLASS_STORE = 2'b10;
    localparam logic [1:0] MEM_SIZE_WORD   = 2'b00;
    localparam logic [1:0] MEM_SIZE_BYTE   = 2'b01; // byte loads zero-extend

    // address split {tag, index, offset}
    localparam int OFFSET_W   = 4;
    localparam int OFFSET_LSB = 0;
    localparam int INDEX_W    = 8;
    localparam int INDEX_LSB  = 4;
    localparam int TAG_W      = 20;
    localparam int TAG_LSB    = 12;

    localparam int SETS        = 256;            // sets per way
    localparam int LINE_W      = 128;            // four words
    localparam int TAG_ENTRY_W = 21;             // {valid, tag}

    // dcache controller states
    localparam logic [1:0] DC_IDLE      = 2'd0;
    localparam logic [1:0] DC_WRITEBACK = 2'd1;  // dirty victim to l2
    localparam logic [1:0] DC_REFILL    = 2'd2;  // new line from l2
    localparam logic [1:0] DC_FILL      = 2'd3;  // line lands in l1

    // word 0 sits at the lowest address
    typedef union packed {
        logic [LINE_W-1:0]                      raw;
        logic [LINE_W/WORD_W-1:0][WORD_W-1:0]   words;
    } cache_line_u;

endpackage

//--- src/mem_ctrl.sv
`timescale 1ns/1ps

module mem_ctrl (
    input  logic                           ex_en,          // ex/mem fields valid
    input  logic [mem_pkg::MEM_OP_W-1:0]   ex_mem_op,      // {class, size}
    input  logic [mem_pkg::WORD_W-1:0]     ex_mem_wr_data, // store data
    input  logic [mem_pkg::WORD_W-1:0]     ex_out,         // alu result, doubles as address
    input  mem_pkg::cache_line_u           read_line,      // line of the hit way
    input  logic                           hit,
    output logic [mem_pkg::WORD_W-1:0]     addr,
    output logic [mem_pkg::WORD_W-1:0]     wr_data,        // store word, byte replicated
    output mem_pkg::cache_line_u           wr_line,        // read_line with store merged
    output logic                           memwrite,
    output logic                           access_mem,
    output logic [mem_pkg::WORD_W-1:0]     out,            // stage result
    output logic                           miss_align
);

    logic [1:0]                 op_class;
    logic [1:0]                 op_size;
    logic                       is_load;
    logic                       is_store;
    logic                       is_byte;
    logic [1:0]                 word_sel;  // word within line
    logic [1:0]                 byte_sel;  // byte within word
    logic [mem_pkg::WORD_W-1:0] ld_word;
    logic [7:0]                 ld_byte;

    assign op_class = ex_mem_op[3:2];
    assign op_size  = ex_mem_op[1:0];
    assign is_load  = ex_en && (op_class == mem_pkg::MEM_CLASS_LOAD);
    assign is_store = ex_en && (op_class == mem_pkg::MEM_CLASS_STORE);
    assign is_byte  = op_size == mem_pkg::MEM_SIZE_BYTE;

    assign addr     = ex_out;
    assign word_sel = addr[mem_pkg::OFFSET_LSB+2 +: 2];
    assign byte_sel = addr[mem_pkg::OFFSET_LSB +: 2];

    // only word accesses can be misaligned
    assign miss_align = (is_load || is_store) && (op_size == mem_pkg::MEM_SIZE_WORD)
                        && (byte_sel != 2'b00);
    assign access_mem = (is_load || is_store) && !miss_align;
    assign memwrite   = is_store && !miss_align;

    assign ld_word = read_line.words[word_sel];
    assign ld_byte = ld_word[{byte_sel, 3'b000} +: 8];
    assign wr_data = is_byte ? {4{ex_mem_wr_data[7:0]}} : ex_mem_wr_data;

    always_comb begin
        wr_line = read_line;  // untouched bytes keep cache contents
        if (is_byte) begin
            wr_line.words[word_sel][{byte_sel, 3'b000} +: 8] = wr_data[7:0];
        end else begin
            wr_line.words[word_sel] = wr_data;
        end
    end

    always_comb begin
        out = ex_out;  // non-loads pass the ex result
        if (is_load && hit) begin
            out = is_byte ? {{(mem_pkg::WORD_W-8){1'b0}}, ld_byte} : ld_word;
        end
    end

endmodule

//--- src/dcache_ctrl.sv
`timescale 1ns/1ps

module dcache_ctrl (
    input  logic                              clk,
    input  logic                              rst,
    input  logic [mem_pkg::WORD_W-1:0]        addr,        // cpu address
    input  mem_pkg::cache_line_u              wr_line,     // merged store line
    input  logic                              memwrite,
    input  logic                              access_mem,
    input  logic                              lru,         // way to replace next
    input  logic [mem_pkg::TAG_ENTRY_W-1:0]   tag0_rd,
    input  logic [mem_pkg::TAG_ENTRY_W-1:0]   tag1_rd,
    input  logic [mem_pkg::LINE_W-1:0]        data0_rd,
    input  logic [mem_pkg::LINE_W-1:0]        data1_rd,
    input  logic                              dirty0,
    input  logic                              dirty1,
    input  logic                              l2_busy,
    input  logic                              l2_rdy,
    input  logic [mem_pkg::LINE_W-1:0]        l2_rd_data,
    output mem_pkg::cache_line_u              read_line,   // line of the hit way
    output logic                              hit,
    output logic                              hitway,      // 1 = way 1
    output logic                              miss_stall,
    output logic [mem_pkg::INDEX_W-1:0]       index,
    output logic [mem_pkg::TAG_ENTRY_W-1:0]   tag_wd,
    output logic                              tag0_rw,
    output logic                              tag1_rw,
    output logic [mem_pkg::LINE_W-1:0]        data_wd_dc,
    output logic                              data0_rw,
    output logic                              data1_rw,
    output logic                              dirty_wd,
    output logic                              dirty0_rw,
    output logic                              dirty1_rw,
    output logic                              lru_wr,      // flip lru of this set
    output logic                              irq,         // l2 request
    output logic                              l2_cache_rw, // 1 = write back
    output logic [mem_pkg::WORD_W-1:0]        l2_addr,     // line address
    output logic [mem_pkg::LINE_W-1:0]        l2_wr_data
);

    logic [1:0]                 state;
    logic                       victim;     // way picked at the miss
    logic [mem_pkg::LINE_W-1:0] fill_line;  // refill data from l2
    logic                       hit0;
    logic                       hit1;
    logic                       in_idle;
    logic                       vic_dirty;
    logic                       l2_done;    // request accepted this cycle
    logic [mem_pkg::TAG_W-1:0]  addr_tag;
    logic [mem_pkg::TAG_W-1:0]  vic_tag;

    assign index    = addr[mem_pkg::INDEX_LSB +: mem_pkg::INDEX_W];
    assign addr_tag = addr[mem_pkg::TAG_LSB +: mem_pkg::TAG_W];

    // tag compare, valid is the top entry bit
    assign hit0 = tag0_rd[mem_pkg::TAG_ENTRY_W-1] && (tag0_rd[mem_pkg::TAG_W-1:0] == addr_tag);
    assign hit1 = tag1_rd[mem_pkg::TAG_ENTRY_W-1] && (tag1_rd[mem_pkg::TAG_W-1:0] == addr_tag);

    assign in_idle        = state == mem_pkg::DC_IDLE;
    assign hit            = access_mem && in_idle && (hit0 || hit1);
    assign hitway         = hit1;
    assign read_line.raw  = hitway ? data1_rd : data0_rd;
    assign miss_stall     = !in_idle || (access_mem && !hit);
    assign vic_dirty      = lru ? (tag1_rd[mem_pkg::TAG_ENTRY_W-1] && dirty1)
                                : (tag0_rd[mem_pkg::TAG_ENTRY_W-1] && dirty0);
    assign l2_done        = irq && l2_rdy;

    // array is not written during the l2 phases, so these hold steady
    assign vic_tag     = victim ? tag1_rd[mem_pkg::TAG_W-1:0] : tag0_rd[mem_pkg::TAG_W-1:0];
    assign l2_cache_rw = state == mem_pkg::DC_WRITEBACK;
    assign l2_addr     = {l2_cache_rw ? vic_tag : addr_tag, index, {mem_pkg::OFFSET_W{1'b0}}};
    assign l2_wr_data  = victim ? data1_rd : data0_rd;

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= mem_pkg::DC_IDLE;
            victim <= 1'b0;
            irq    <= 1'b0;
        end else begin
            case (state)
                mem_pkg::DC_IDLE: begin
                    if (access_mem && !hit) begin
                        victim <= lru;  // replace least recently used way
                        state  <= vic_dirty ? mem_pkg::DC_WRITEBACK : mem_pkg::DC_REFILL;
                    end
                end
                mem_pkg::DC_WRITEBACK, mem_pkg::DC_REFILL: begin
                    if (l2_done) begin
                        irq   <= 1'b0;
                        state <= l2_cache_rw ? mem_pkg::DC_REFILL : mem_pkg::DC_FILL;
                    end else if (!irq && !l2_busy) begin
                        irq <= 1'b1;  // raise only when l2 is free
                    end
                end
                default: state <= mem_pkg::DC_IDLE;  // fill done
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state == mem_pkg::DC_REFILL) && l2_done) begin
            fill_line <= l2_rd_data;
        end
    end

    always_comb begin
        tag_wd     = {1'b1, addr_tag};  // only fills write tags
        data_wd_dc = wr_line.raw;
        dirty_wd   = 1'b1;
        tag0_rw    = 1'b0;
        tag1_rw    = 1'b0;
        data0_rw   = 1'b0;
        data1_rw   = 1'b0;
        dirty0_rw  = 1'b0;
        dirty1_rw  = 1'b0;
        lru_wr     = hit && (hitway == lru);  // point lru at the other way
        if (hit && memwrite) begin
            data0_rw  = !hitway;
            data1_rw  = hitway;
            dirty0_rw = !hitway;
            dirty1_rw = hitway;
        end else if (state == mem_pkg::DC_FILL) begin
            data_wd_dc = fill_line;
            dirty_wd   = 1'b0;  // fresh line is clean
            tag0_rw    = !victim;
            tag1_rw    = victim;
            data0_rw   = !victim;
            data1_rw   = victim;
            dirty0_rw  = !victim;
            dirty1_rw  = victim;
        end
    end

endmodule

//--- src/mem_reg.sv
`timescale 1ns/1ps

module mem_reg (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              hold,         // pipeline or miss stall
    input  logic                              flush,
    input  logic                              ex_en,
    input  logic [mem_pkg::REG_ADDR_W-1:0]    ex_dst_addr,
    input  logic                              ex_gpr_we_,   // active low
    input  logic [mem_pkg::WORD_W-1:0]        out,          // stage result
    input  logic                              miss_align,
    output logic                              mem_en,
    output logic [mem_pkg::REG_ADDR_W-1:0]    mem_dst_addr,
    output logic                              mem_gpr_we_,
    output logic [mem_pkg::WORD_W-1:0]        mem_out
);

    always_ff @(posedge clk) begin
        if (rst) begin
            mem_en       <= 1'b0;
            mem_dst_addr <= '0;
            mem_gpr_we_  <= 1'b1;
            mem_out      <= '0;
        end else if (!hold) begin
            if (flush) begin
                mem_en       <= 1'b0;  // bubble
                mem_dst_addr <= '0;
                mem_gpr_we_  <= 1'b1;
                mem_out      <= '0;
            end else begin
                mem_en       <= ex_en;
                mem_dst_addr <= ex_dst_addr;
                mem_gpr_we_  <= ex_gpr_we_ || miss_align;  // no write on misalign
                mem_out      <= out;
            end
        end
    end

endmodule

//--- src/l1_dcache_array.sv
`timescale 1ns/1ps

module l1_dcache_array (
    input  logic                              clk,
    input  logic                              rst,
    input  logic [mem_pkg::INDEX_W-1:0]       index,
    input  logic [mem_pkg::TAG_ENTRY_W-1:0]   tag_wd,     // {valid, tag}
    input  logic                              tag0_rw,
    input  logic                              tag1_rw,
    input  logic [mem_pkg::LINE_W-1:0]        data_wd_dc,
    input  logic                              data0_rw,
    input  logic                              data1_rw,
    input  logic                              dirty_wd,
    input  logic                              dirty0_rw,
    input  logic                              dirty1_rw,
    input  logic                              lru_wr,     // toggle lru of the set
    output logic [mem_pkg::TAG_ENTRY_W-1:0]   tag0_rd,
    output logic [mem_pkg::TAG_ENTRY_W-1:0]   tag1_rd,
    output logic [mem_pkg::LINE_W-1:0]        data0_rd,
    output logic [mem_pkg::LINE_W-1:0]        data1_rd,
    output logic                              dirty0,
    output logic                              dirty1,
    output logic                              lru
);

    logic [mem_pkg::TAG_W-1:0] tag_mem  [2][mem_pkg::SETS];
    mem_pkg::cache_line_u      data_mem [2][mem_pkg::SETS];
    logic [1:0][mem_pkg::SETS-1:0] valid_bits;
    logic [1:0][mem_pkg::SETS-1:0] dirty_bits;
    logic [mem_pkg::SETS-1:0]      lru_bits;
    logic [1:0] tag_we;
    logic [1:0] data_we;
    logic [1:0] dirty_we;

    assign tag_we   = {tag1_rw, tag0_rw};
    assign data_we  = {data1_rw, data0_rw};
    assign dirty_we = {dirty1_rw, dirty0_rw};

    always_ff @(posedge clk) begin
        for (int w = 0; w < 2; w++) begin
            if (tag_we[w]) begin
                tag_mem[w][index] <= tag_wd[mem_pkg::TAG_W-1:0];
            end
            if (data_we[w]) begin
                data_mem[w][index].raw <= data_wd_dc;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_bits <= '0;
            dirty_bits <= '0;
            lru_bits   <= '0;
        end else begin
            for (int w = 0; w < 2; w++) begin
                if (tag_we[w]) begin
                    valid_bits[w][index] <= tag_wd[mem_pkg::TAG_ENTRY_W-1];
                end
                if (dirty_we[w]) begin
                    dirty_bits[w][index] <= dirty_wd;
                end
            end
            if (lru_wr) begin
                lru_bits[index] <= !lru_bits[index];
            end
        end
    end

    // combinational read of the addressed set
    assign tag0_rd  = {valid_bits[0][index], tag_mem[0][index]};
    assign tag1_rd  = {valid_bits[1][index], tag_mem[1][index]};
    assign data0_rd = data_mem[0][index].raw;
    assign data1_rd = data_mem[1][index].raw;
    assign dirty0   = dirty_bits[0][index];
    assign dirty1   = dirty_bits[1][index];
    assign lru      = lru_bits[index];

endmodule

//--- src/mem_stage.sv
`timescale 1ns/1ps

module mem_stage (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              stall,
    input  logic                              flush,
    input  logic                              ex_en,
    input  logic [mem_pkg::MEM_OP_W-1:0]      ex_mem_op,
    input  logic [mem_pkg::WORD_W-1:0]        ex_mem_wr_data,
    input  logic [mem_pkg::REG_ADDR_W-1:0]    ex_dst_addr,
    input  logic                              ex_gpr_we_,
    input  logic [mem_pkg::WORD_W-1:0]        ex_out,
    output logic [mem_pkg::WORD_W-1:0]        fwd_data,     // forward to ex
    output logic                              miss_stall,
    output logic                              mem_en,
    output logic [mem_pkg::REG_ADDR_W-1:0]    mem_dst_addr,
    output logic                              mem_gpr_we_,
    output logic [mem_pkg::WORD_W-1:0]        mem_out,
    // l2 side
    input  logic                              l2_busy,
    input  logic                              l2_rdy,
    input  logic [mem_pkg::LINE_W-1:0]        l2_rd_data,
    output logic                              irq,
    output logic                              l2_cache_rw,
    output logic [mem_pkg::WORD_W-1:0]        l2_addr,
    output logic [mem_pkg::LINE_W-1:0]        l2_wr_data,
    // l1 array side
    input  logic                              lru,
    input  logic [mem_pkg::TAG_ENTRY_W-1:0]   tag0_rd,
    input  logic [mem_pkg::TAG_ENTRY_W-1:0]   tag1_rd,
    input  logic [mem_pkg::LINE_W-1:0]        data0_rd,
    input  logic [mem_pkg::LINE_W-1:0]        data1_rd,
    input  logic                              dirty0,
    input  logic                              dirty1,
    output logic [mem_pkg::INDEX_W-1:0]       index,
    output logic [mem_pkg::TAG_ENTRY_W-1:0]   tag_wd,
    output logic                              tag0_rw,
    output logic                              tag1_rw,
    output logic [mem_pkg::LINE_W-1:0]        data_wd_dc,
    output logic                              data0_rw,
    output logic                              data1_rw,
    output logic                              dirty_wd,
    output logic                              dirty0_rw,
    output logic                              dirty1_rw,
    output logic                              lru_wr
);

    logic [mem_pkg::WORD_W-1:0] addr;
    logic [mem_pkg::WORD_W-1:0] out;         // load data or ex result
    mem_pkg::cache_line_u       wr_line;
    mem_pkg::cache_line_u       read_line;
    logic                       memwrite;
    logic                       access_mem;
    logic                       hit;
    logic                       miss_align;
    logic                       hold;        // freeze mem/wb

    assign fwd_data = out;
    assign hold     = stall || miss_stall;

    // store word is already folded into wr_line, hit way into read_line
    mem_ctrl mem_ctrl_i (.wr_data (), .*);

    dcache_ctrl dcache_ctrl_i (.hitway (), .*);

    mem_reg mem_reg_i (.*);

endmodule

//--- src/dcache_mem_top.sv
`timescale 1ns/1ps

module dcache_mem_top (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              stall,
    input  logic                              flush,
    input  logic                              ex_en,
    input  logic [mem_pkg::MEM_OP_W-1:0]      ex_mem_op,
    input  logic [mem_pkg::WORD_W-1:0]        ex_mem_wr_data,
    input  logic [mem_pkg::REG_ADDR_W-1:0]    ex_dst_addr,
    input  logic                              ex_gpr_we_,
    input  logic [mem_pkg::WORD_W-1:0]        ex_out,
    output logic [mem_pkg::WORD_W-1:0]        fwd_data,
    output logic                              miss_stall,
    output logic                              mem_en,
    output logic [mem_pkg::REG_ADDR_W-1:0]    mem_dst_addr,
    output logic                              mem_gpr_we_,
    output logic [mem_pkg::WORD_W-1:0]        mem_out,
    input  logic                              l2_busy,      // l2 model
    input  logic                              l2_rdy,
    input  logic [mem_pkg::LINE_W-1:0]        l2_rd_data,
    output logic                              irq,
    output logic                              l2_cache_rw,
    output logic [mem_pkg::WORD_W-1:0]        l2_addr,
    output logic [mem_pkg::LINE_W-1:0]        l2_wr_data
);

    // stage to array
    logic [mem_pkg::INDEX_W-1:0]     index;
    logic [mem_pkg::TAG_ENTRY_W-1:0] tag_wd;
    logic [mem_pkg::LINE_W-1:0]      data_wd_dc;
    logic tag0_rw;
    logic tag1_rw;
    logic data0_rw;
    logic data1_rw;
    logic dirty_wd;
    logic dirty0_rw;
    logic dirty1_rw;
    logic lru_wr;
    // array to stage
    logic [mem_pkg::TAG_ENTRY_W-1:0] tag0_rd;
    logic [mem_pkg::TAG_ENTRY_W-1:0] tag1_rd;
    logic [mem_pkg::LINE_W-1:0]      data0_rd;
    logic [mem_pkg::LINE_W-1:0]      data1_rd;
    logic dirty0;
    logic dirty1;
    logic lru;

    mem_stage mem_stage_i (.*);

    l1_dcache_array l1_dcache_array_i (.*);

endmodule

//--- verification/dcache_assertions.sv
`timescale 1ns/1ps

module dcache_assertions (
    input logic clk,
    input logic rst,
    input logic irq,
    input logic l2_busy,
    input logic l2_rdy,
    input logic tag0_rw,
    input logic tag1_rw,
    input logic data0_rw,
    input logic data1_rw,
    input logic dirty0_rw,
    input logic dirty1_rw,
    input logic lru_wr
);

    int   fail_count = 0;  // read by the testbench at the end
    logic any_write;

    assign any_write = tag0_rw || tag1_rw || data0_rw || data1_rw
                       || dirty0_rw || dirty1_rw || lru_wr;

    // request may only start when l2 is free
    irq_rise_when_free: assert property (@(posedge clk) disable iff (rst)
        $rose(irq) |-> !$past(l2_busy))
        else begin
            fail_count++;
            $error("irq rose while l2_busy was high");
        end

    // request held until l2 answers
    irq_held_until_rdy: assert property (@(posedge clk) disable iff (rst)
        irq && !l2_rdy |=> irq)
        else begin
            fail_count++;
            $error("irq dropped before l2_rdy");
        end

    no_write_in_reset: assert property (@(posedge clk)
        rst && $past(rst) |-> !any_write)
        else begin
            fail_count++;
            $error("array write strobe active during reset");
        end

    one_tag_write: assert property (@(posedge clk) disable iff (rst)
        !(tag0_rw && tag1_rw))
        else begin
            fail_count++;
            $error("both tag ways written in one cycle");
        end

endmodule

bind dcache_ctrl dcache_assertions dcache_assertions_i (.*);

//--- verification/tb_mem_stage.sv
`timescale 1ns/1ps

module tb_mem_stage;

    localparam int RESET_CYCLES = 16;
    localparam int OP_COUNT     = 20;   // directed accesses, rounded up
    localparam int WORST_MISS   = 14;   // write-back, refill and fill
    localparam int CYCLE_LIMIT  = RESET_CYCLES + OP_COUNT * WORST_MISS * 2;
    localparam int L2_WAIT      = 2;    // busy cycles at the start of a request
    localparam logic [3:0] LW = {mem_pkg::MEM_CLASS_LOAD, mem_pkg::MEM_SIZE_WORD};
    localparam logic [3:0] SW = {mem_pkg::MEM_CLASS_STORE, mem_pkg::MEM_SIZE_WORD};

    logic                           clk;
    logic                           rst;
    logic                           stall;
    logic                           flush;
    logic                           ex_en;
    logic [mem_pkg::MEM_OP_W-1:0]   ex_mem_op;
    logic [mem_pkg::WORD_W-1:0]     ex_mem_wr_data;
    logic [mem_pkg::REG_ADDR_W-1:0] ex_dst_addr;
    logic                           ex_gpr_we_;
    logic [mem_pkg::WORD_W-1:0]     ex_out;
    logic [mem_pkg::WORD_W-1:0]     fwd_data;
    logic                           miss_stall;
    logic                           mem_en;
    logic [mem_pkg::REG_ADDR_W-1:0] mem_dst_addr;
    logic                           mem_gpr_we_;
    logic [mem_pkg::WORD_W-1:0]     mem_out;
    logic                           l2_busy;
    logic                           l2_rdy;
    logic [mem_pkg::LINE_W-1:0]     l2_rd_data;
    logic                           irq;
    logic                           l2_cache_rw;
    logic [mem_pkg::WORD_W-1:0]     l2_addr;
    logic [mem_pkg::LINE_W-1:0]     l2_wr_data;

    mem_pkg::cache_line_u       l2_mem [4096];     // l2 image, line addressed
    logic [mem_pkg::WORD_W-1:0] ref_words [16384]; // expected cpu view
    mem_pkg::cache_line_u       last_wb_line;
    logic [mem_pkg::WORD_W-1:0] last_wb_addr;
    logic [mem_pkg::WORD_W-1:0] pattern;
    integer                     seed;
    int                         req_count;         // l2 requests seen
    int                         cycle_count;
    int                         checks;
    int                         errors;
    int                         assert_errors;

    dcache_mem_top dcache_mem_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // l2 model
    initial begin
        seed         = 8;
        pattern      = $random(seed);
        l2_busy      = 1'b0;
        l2_rdy       = 1'b0;
        l2_rd_data   = '0;
        req_count    = 0;
        last_wb_addr = '0;
        last_wb_line = '0;
        for (int i = 0; i < 16384; i++) begin
            ref_words[i] = {16'h0, i[13:0], 2'b00} ^ pattern;  // address xor pattern
            l2_mem[i[13:2]].words[i[1:0]] = ref_words[i];
        end
        forever begin
            @(posedge clk);
            #1;
            if (irq === 1'b1) begin
                req_count++;
                l2_busy = 1'b1;
                repeat (L2_WAIT) @(posedge clk);
                #1;
                l2_busy = 1'b0;
                l2_rdy  = 1'b1;
                if (l2_cache_rw) begin  // victim line comes back
                    l2_mem[l2_addr[15:4]].raw = l2_wr_data;
                    last_wb_addr      = l2_addr;
                    last_wb_line.raw  = l2_wr_data;
                end else begin
                    l2_rd_data = l2_mem[l2_addr[15:4]].raw;
                end
                @(posedge clk);
                #1;
                l2_rdy = 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, an access never completed", cycle_count);
            $display("Test failed");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("FAIL %s expected %h actual %h", name, expected, actual);
        end
    endtask

    // one access, wait out any miss, check mem/wb one edge later
    task automatic do_access(input string name, input logic [3:0] op, input logic [31:0] a,
                             input logic [31:0] wdata, input logic [31:0] exp_out,
                             input logic exp_we_);
        ex_en          = 1'b1;
        ex_mem_op      = op;
        ex_out         = a;
        ex_mem_wr_data = wdata;
        ex_dst_addr    = a[6:2];                               // any gpr
        ex_gpr_we_     = op[3:2] != mem_pkg::MEM_CLASS_LOAD;   // loads write back
        @(negedge clk);
        while (miss_stall) begin
            @(negedge clk);
        end
        check_value({name, " fwd_data"}, exp_out, fwd_data);  // forward path, before the edge
        @(posedge clk);
        #1;
        check_value({name, " mem_out"}, exp_out, mem_out);
        check_value({name, " mem_gpr_we_"}, {31'b0, exp_we_}, {31'b0, mem_gpr_we_});
        check_value({name, " mem_en"}, 32'd1, {31'b0, mem_en});
        ex_en     = 1'b0;  // bubble
        ex_mem_op = '0;
    endtask

    task automatic load_check(input string name, input logic [1:0] size,
                              input logic [31:0] a);
        logic [31:0] word;
        logic [31:0] expected;
        word = ref_words[a[15:2]];
        if (size == mem_pkg::MEM_SIZE_BYTE) begin
            expected = {24'h0, word[{a[1:0], 3'b000} +: 8]};  // zero-extended
        end else begin
            expected = word;
        end
        do_access(name, {mem_pkg::MEM_CLASS_LOAD, size}, a, 32'h0, expected, 1'b0);
    endtask

    task automatic store_check(input string name, input logic [1:0] size,
                               input logic [31:0] a, input logic [31:0] data);
        if (size == mem_pkg::MEM_SIZE_BYTE) begin
            ref_words[a[15:2]][{a[1:0], 3'b000} +: 8] = data[7:0];
        end else begin
            ref_words[a[15:2]] = data;
        end
        do_access(name, {mem_pkg::MEM_CLASS_STORE, size}, a, data, a, 1'b1);  // out = address
    endtask

    task automatic reset_test();
        check_value("reset mem_en", 32'd0, {31'b0, mem_en});
        check_value("reset mem_gpr_we_", 32'd1, {31'b0, mem_gpr_we_});
        check_value("reset irq", 32'd0, {31'b0, irq});
        check_value("reset miss_stall", 32'd0, {31'b0, miss_stall});
    endtask

    task automatic load_miss_hit_test();
        int req_before;
        load_check("load_miss", mem_pkg::MEM_SIZE_WORD, 32'h0000_0100);
        req_before = req_count;
        load_check("load_hit", mem_pkg::MEM_SIZE_WORD, 32'h0000_0104);
        check_value("load_hit l2 requests", req_before, req_count);  // no irq on a hit
    endtask

    task automatic store_test();
        store_check("store_word", mem_pkg::MEM_SIZE_WORD, 32'h0000_0108, 32'hdead_beef);
        load_check("store_word reload", mem_pkg::MEM_SIZE_WORD, 32'h0000_0108);
        store_check("store_byte", mem_pkg::MEM_SIZE_BYTE, 32'h0000_0109, 32'h0000_00a5);
        load_check("store_byte reload", mem_pkg::MEM_SIZE_BYTE, 32'h0000_0109);
        load_check("store_merged word", mem_pkg::MEM_SIZE_WORD, 32'h0000_0108);
        load_check("load_byte top", mem_pkg::MEM_SIZE_BYTE, 32'h0000_010b);  // 0xde, no sign
    endtask

    // three tags on set 0x20
    task automatic eviction_test();
        store_check("evict store_a", mem_pkg::MEM_SIZE_WORD, 32'h0000_1200, 32'h600d_cafe);
        load_check("evict load_b", mem_pkg::MEM_SIZE_WORD, 32'h0000_2200);
        load_check("evict load_c", mem_pkg::MEM_SIZE_WORD, 32'h0000_3200);  // a is lru, dirty
        check_value("evict wb_addr", 32'h0000_1200, last_wb_addr);
        check_value("evict wb_data", 32'h600d_cafe, last_wb_line.words[0]);
        load_check("evict reload_a", mem_pkg::MEM_SIZE_WORD, 32'h0000_1200);
    endtask

    task automatic misalign_test();
        int req_before;
        req_before = req_count;
        do_access("misalign_load", LW, 32'h0000_0502, 32'h0, 32'h0000_0502, 1'b1);
        do_access("misalign_store", SW, 32'h0000_0106, 32'h1234_5678, 32'h0000_0106, 1'b1);
        check_value("misalign l2 requests", req_before, req_count);
        load_check("misalign reload", mem_pkg::MEM_SIZE_WORD, 32'h0000_0104);
    endtask

    task automatic stall_flush_test();
        logic [31:0] out_q;
        logic [4:0]  dst_q;
        logic        we_q;
        load_check("stall load", mem_pkg::MEM_SIZE_WORD, 32'h0000_0104);
        out_q = mem_out;
        dst_q = mem_dst_addr;
        we_q  = mem_gpr_we_;
        stall       = 1'b1;
        ex_mem_op   = LW;
        ex_out      = 32'h0000_0108;
        ex_dst_addr = 5'd9;
        ex_gpr_we_  = 1'b1;  // bubble fields all differ from the held ones
        @(posedge clk);
        #1;
        check_value("stall mem_out", out_q, mem_out);
        check_value("stall mem_dst_addr", {27'b0, dst_q}, {27'b0, mem_dst_addr});
        check_value("stall mem_gpr_we_", {31'b0, we_q}, {31'b0, mem_gpr_we_});
        check_value("stall mem_en", 32'd1, {31'b0, mem_en});
        stall      = 1'b0;
        flush      = 1'b1;
        ex_en      = 1'b1;  // valid load hit, flush still empties mem/wb
        ex_gpr_we_ = 1'b0;
        @(posedge clk);
        #1;
        check_value("flush mem_en", 32'd0, {31'b0, mem_en});
        check_value("flush mem_gpr_we_", 32'd1, {31'b0, mem_gpr_we_});
        flush      = 1'b0;
        ex_en      = 1'b0;
        ex_mem_op  = '0;
        ex_gpr_we_ = 1'b1;
    endtask

    initial begin
        rst            = 1'b1;
        stall          = 1'b0;
        flush          = 1'b0;
        ex_en          = 1'b0;
        ex_mem_op      = '0;
        ex_mem_wr_data = '0;
        ex_dst_addr    = '0;
        ex_gpr_we_     = 1'b1;
        ex_out         = '0;
        cycle_count    = 0;
        checks         = 0;
        errors         = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
        reset_test();
        load_miss_hit_test();
        store_test();
        eviction_test();
        misalign_test();
        stall_flush_test();
        assert_errors = dcache_mem_top_i.mem_stage_i.dcache_ctrl_i.dcache_assertions_i.fail_count;
        $display("checks %0d, value errors %0d, assertion failures %0d",
                 checks, errors, assert_errors);
        if (errors == 0 && assert_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- project.f
src/mem_pkg.sv
src/mem_ctrl.sv
src/dcache_ctrl.sv
src/mem_reg.sv
src/l1_dcache_array.sv
src/mem_stage.sv
src/dcache_mem_top.sv
verification/dcache_assertions.sv
verification/tb_mem_stage.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       := tb_mem_stage
FILELIST  := project.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := Test completed successfully
SIM_ARGS  := +verilator+error+limit+100

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
